/* mio_defines.svh */
`ifndef MIO_DEFINES_SVH
`define MIO_DEFINES_SVH

// ####################
// Link geometry
// ####################

`define MIO_AW          32                      // Address width

`define MIO_PW          (2*`MIO_AW+40)          // Packet width, 104 bits

`define MIO_NMIO        8                       // Link beat width

`define MIO_NBEATS      (`MIO_PW/`MIO_NMIO)     // Beats per packet, 13

// ####################
// Packet buffer
// ####################

`define MIO_FIFO_DEPTH  4                       // Packets held, power of two

`endif

/* mio_pkg.sv */
`include "mio_defines.svh"

package mio_pkg;

   // ####################
   // Data widths
   // ####################

   typedef logic [`MIO_PW-1:0]   mio_packet_t;    // One full packet
   typedef logic [`MIO_NMIO-1:0] mio_beat_t;      // One link beat
   typedef logic [3:0]           mio_beat_cnt_t;  // Beat index within packet

   // ####################
   // Serializer FSM
   // ####################

   typedef enum logic {
      ser_idle,                                   // Waiting for a packet
      ser_send                                    // Beats on the link
   } mio_ser_state_t;

endpackage

/* mio_packet_fifo.sv */
`timescale 1ns/10ps
`include "mio_defines.svh"

module mio_packet_fifo (
   input  logic                sys_clk,
   input  logic                rst_n,
   input  logic                tx_access,     // Single-cycle write strobe
   input  mio_pkg::mio_packet_t tx_packet,     // Valid with tx_access
   input  logic                fifo_pop,      // Consume head packet
   output mio_pkg::mio_packet_t fifo_packet,   // Show-ahead head
   output logic                fifo_empty,
   output logic                tx_full,
   output logic                tx_overflow    // Sticky until reset
);

   localparam int PTR_W = $clog2(`MIO_FIFO_DEPTH);
   localparam int CNT_W = PTR_W + 1;
   localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(`MIO_FIFO_DEPTH);

   mio_pkg::mio_packet_t mem [`MIO_FIFO_DEPTH];  // Packet storage
   logic [PTR_W-1:0]     wr_ptr;                  // Next free slot
   logic [PTR_W-1:0]     rd_ptr;                  // Oldest packet
   logic [CNT_W-1:0]     count;                   // Occupancy
   logic                 push;

   assign push        = tx_access && !tx_full;    // Refused when full
   assign fifo_empty  = (count == '0);
   assign tx_full     = (count == FULL_CNT);
   assign fifo_packet = mem[rd_ptr];              // Head always visible

   // ####################
   // Storage
   // ####################

   always_ff @(posedge sys_clk) begin
      if (push) begin
         mem[wr_ptr] <= tx_packet;
      end
   end

   // ####################
   // Pointers and count
   // ####################

   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         count       <= '0;
         tx_overflow <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;              // Wraps at depth
         end
         if (fifo_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, fifo_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;              // Idle or push with pop
         endcase
         if (tx_access && tx_full) begin
            tx_overflow <= 1'b1;                  // Dropped strobe
         end
      end
   end

   // Serializer must only pop a real packet
   a_no_pop_empty: assert property (@(posedge sys_clk) disable iff (!rst_n)
      fifo_pop |-> !fifo_empty);

   // Occupancy within depth and in step with the pointers
   a_count_bound: assert property (@(posedge sys_clk) disable iff (!rst_n)
      (count <= FULL_CNT) && (count[PTR_W-1:0] == wr_ptr - rd_ptr));

endmodule

/* mio_serializer.sv */
`timescale 1ns/10ps
`include "mio_defines.svh"

module mio_serializer (
   input  logic                 sys_clk,
   input  logic                 rst_n,
   input  logic                 fifo_empty,    // Buffer has nothing
   input  mio_pkg::mio_packet_t fifo_packet,   // Show-ahead head
   output logic                 fifo_pop,      // Take head this cycle
   output logic                 link_access,   // Beat valid
   output mio_pkg::mio_beat_t   link_data      // Current beat
);

   localparam mio_pkg::mio_beat_cnt_t LAST_BEAT =
      mio_pkg::mio_beat_cnt_t'(`MIO_NBEATS - 1);

   mio_pkg::mio_ser_state_t state;
   mio_pkg::mio_beat_cnt_t  beat_cnt;             // Beat now on the link
   mio_pkg::mio_packet_t    shift_reg;            // MSB beat on top
   logic                    last_beat;

   // ####################
   // Pop decision
   // ####################

   assign last_beat = (state == mio_pkg::ser_send) && (beat_cnt == LAST_BEAT);

   // Load from idle, or reload under the final beat for gapless packets
   assign fifo_pop = !fifo_empty &&
                     ((state == mio_pkg::ser_idle) || last_beat);

   assign link_access = (state == mio_pkg::ser_send);
   assign link_data   = shift_reg[`MIO_PW-1 -: `MIO_NMIO];  // MSB first

   // ####################
   // FSM
   // ####################

   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= mio_pkg::ser_idle;
         beat_cnt <= '0;
      end else begin
         case (state)
            mio_pkg::ser_idle: begin
               beat_cnt <= '0;
               if (fifo_pop) begin
                  state <= mio_pkg::ser_send;    // Beat 0 next cycle
               end
            end
            mio_pkg::ser_send: begin
               if (last_beat) begin
                  beat_cnt <= '0;
                  if (!fifo_pop) begin
                     state <= mio_pkg::ser_idle; // Nothing waiting
                  end
               end else begin
                  beat_cnt <= beat_cnt + 4'd1;
               end
            end
            default: begin
               state    <= mio_pkg::ser_idle;
               beat_cnt <= '0;
            end
         endcase
      end
   end

   // ####################
   // Shift register
   // ####################

   always_ff @(posedge sys_clk) begin
      if (fifo_pop) begin
         shift_reg <= fifo_packet;               // New packet
      end else if (state == mio_pkg::ser_send) begin
         shift_reg <= {shift_reg[`MIO_PW-`MIO_NMIO-1:0], {`MIO_NMIO{1'b0}}};
      end
   end

   // Every packet leaves as one unbroken run of beats
   a_packet_run: assert property (@(posedge sys_clk) disable iff (!rst_n)
      (link_access && (beat_cnt == '0)) |-> link_access [*`MIO_NBEATS]);

endmodule

/* mio_deserializer.sv */
`timescale 1ns/10ps
`include "mio_defines.svh"

module mio_deserializer (
   input  logic                 sys_clk,
   input  logic                 rst_n,
   input  logic                 link_access,   // Beat valid
   input  mio_pkg::mio_beat_t   link_data,     // MSB beat first
   output logic                 rx_access,     // One-cycle packet strobe
   output mio_pkg::mio_packet_t rx_packet      // Valid with rx_access
);

   localparam mio_pkg::mio_beat_cnt_t LAST_BEAT =
      mio_pkg::mio_beat_cnt_t'(`MIO_NBEATS - 1);

   mio_pkg::mio_beat_cnt_t          rx_cnt;     // Beats collected so far
   logic [`MIO_PW-`MIO_NMIO-1:0]    asm_reg;    // All but the final beat
   logic                            rx_last;

   // ####################
   // Framing
   // ####################

   assign rx_last = link_access && (rx_cnt == LAST_BEAT);

   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_cnt    <= '0;
         rx_access <= 1'b0;
      end else begin
         rx_access <= rx_last;                    // Strobe for one cycle
         if (rx_last) begin
            rx_cnt <= '0;                         // Ready for next packet
         end else if (link_access) begin
            rx_cnt <= rx_cnt + 4'd1;
         end
      end
   end

   // ####################
   // Assembly
   // ####################

   always_ff @(posedge sys_clk) begin
      if (link_access) begin
         asm_reg <= {asm_reg[`MIO_PW-2*`MIO_NMIO-1:0], link_data};
      end
   end

   // Final beat goes straight into the output register
   always_ff @(posedge sys_clk) begin
      if (rx_last) begin
         rx_packet <= {asm_reg, link_data};
      end
   end

   // Sender keeps beats back to back inside a packet
   a_no_gap: assert property (@(posedge sys_clk) disable iff (!rst_n)
      (rx_cnt != '0) |-> link_access);

endmodule

/* mio_top.sv */
`timescale 1ns/10ps

module mio_top (
   input  logic                 sys_clk,
   input  logic                 rst_n,
   input  logic                 tx_access,     // Packet write strobe
   input  mio_pkg::mio_packet_t tx_packet,
   output logic                 tx_full,       // Buffer cannot take more
   output logic                 tx_overflow,   // A strobe was dropped
   output logic                 link_access,   // Narrow link, looped back
   output mio_pkg::mio_beat_t   link_data,
   output logic                 rx_access,     // Rebuilt packet strobe
   output mio_pkg::mio_packet_t rx_packet
);

   // ####################
   // Buffer to serializer
   // ####################

   logic                 fifo_pop;
   logic                 fifo_empty;
   mio_pkg::mio_packet_t fifo_packet;

   mio_packet_fifo i_fifo (
      .sys_clk     (sys_clk),
      .rst_n       (rst_n),
      .tx_access   (tx_access),
      .tx_packet   (tx_packet),
      .fifo_pop    (fifo_pop),
      .fifo_packet (fifo_packet),
      .fifo_empty  (fifo_empty),
      .tx_full     (tx_full),
      .tx_overflow (tx_overflow)
   );

   mio_serializer i_ser (
      .sys_clk     (sys_clk),
      .rst_n       (rst_n),
      .fifo_empty  (fifo_empty),
      .fifo_packet (fifo_packet),
      .fifo_pop    (fifo_pop),
      .link_access (link_access),   // Also a top output
      .link_data   (link_data)
   );

   // Receiver listens to our own transmit link
   mio_deserializer i_deser (
      .sys_clk     (sys_clk),
      .rst_n       (rst_n),
      .link_access (link_access),
      .link_data   (link_data),
      .rx_access   (rx_access),
      .rx_packet   (rx_packet)
   );

endmodule

/* tb_mio_top.sv */
`timescale 1ns/10ps
`include "mio_defines.svh"

module tb_mio_top;

   logic                 sys_clk;
   logic                 rst_n;
   logic                 tx_access;
   mio_pkg::mio_packet_t tx_packet;
   logic                 tx_full;
   logic                 tx_overflow;
   logic                 link_access;
   mio_pkg::mio_beat_t   link_data;
   logic                 rx_access;
   mio_pkg::mio_packet_t rx_packet;

   int                   err_cnt = 0;
   int                   check_cnt = 0;
   int                   rx_cnt = 0;           // Packets seen on rx
   int                   beat_cnt = 0;         // Link beats seen
   int                   cycle_cnt = 0;        // Rising edges so far
   int                   last_rx_edge = 0;
   int                   strobe_edge = 0;      // Edge that samples the last strobe
   logic [31:0]          lfsr;
   mio_pkg::mio_packet_t exp_q[$];             // Accepted and not yet received
   mio_pkg::mio_packet_t sent_q[$];            // Accepted packets of the current test
   mio_pkg::mio_beat_t   beat_q[$];
   int                   beat_cyc_q[$];

   mio_top i_dut (
      .sys_clk     (sys_clk),
      .rst_n       (rst_n),
      .tx_access   (tx_access),
      .tx_packet   (tx_packet),
      .tx_full     (tx_full),
      .tx_overflow (tx_overflow),
      .link_access (link_access),
      .link_data   (link_data),
      .rx_access   (rx_access),
      .rx_packet   (rx_packet)
   );

   initial sys_clk = 1'b0;
   always #10 sys_clk = ~sys_clk;                // 20 ns period

   always @(posedge sys_clk) begin
      cycle_cnt <= cycle_cnt + 1;
   end

   // ####################
   // Monitor
   // ####################

   // Outputs are all registered, so the falling edge is a quiet point
   always @(negedge sys_clk) begin
      if (rst_n) begin
         if (link_access) begin
            beat_q.push_back(link_data);
            beat_cyc_q.push_back(cycle_cnt);
            beat_cnt++;
         end
         if (rx_access) begin
            rx_cnt++;
            last_rx_edge = cycle_cnt;
            check_cnt++;
            if (exp_q.size() == 0) begin
               err_cnt++;
               $display("Packet received while none was outstanding");
            end else begin
               if (rx_packet !== exp_q[0]) begin
                  report_mismatch("rx_packet", rx_packet, exp_q[0]);
               end
               void'(exp_q.pop_front());
            end
         end
      end
   end

   // ####################
   // Helpers
   // ####################

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];         // x^32+x^22+x^2+x+1
      return {s[30:0], fb};
   endfunction

   task automatic make_packet(output mio_pkg::mio_packet_t pkt);
      for (int b = 0; b < `MIO_PW; b++) begin
         lfsr   = lfsr_step(lfsr);               // One step per bit
         pkt[b] = lfsr[0];
      end
   endtask

   task automatic report_mismatch(input string name, input logic [`MIO_PW-1:0] got,
                                  input logic [`MIO_PW-1:0] exp);
      err_cnt++;
      $display("ERR %s got %h exp %h", name, got, exp);
   endtask

   task automatic clear_capture();
      beat_q.delete();
      beat_cyc_q.delete();
      sent_q.delete();
   endtask

   // Strobe one packet that the buffer must take or drop
   task automatic drive_strobe(input mio_pkg::mio_packet_t pkt, input logic exp_accept);
      @(negedge sys_clk);
      tx_access   = 1'b1;
      tx_packet   = pkt;
      strobe_edge = cycle_cnt + 1;
      check_cnt++;
      if (tx_full !== !exp_accept) begin
         report_mismatch("tx_full", tx_full, !exp_accept);
      end
      if (exp_accept) begin
         exp_q.push_back(pkt);
         sent_q.push_back(pkt);
      end
   endtask

   task automatic idle_inputs();
      @(negedge sys_clk);
      tx_access = 1'b0;
      tx_packet = '0;
   endtask

   task automatic wait_rx(input int target, input int limit);
      int n;
      n = 0;
      while (rx_cnt < target && n < limit) begin
         @(negedge sys_clk);
         n++;
      end
      if (rx_cnt < target) begin
         err_cnt++;
         $display("Timeout waiting for packet %0d, only %0d received", target, rx_cnt);
      end
   endtask

   // Beats must be the sent bytes, MSB first, on consecutive cycles
   task automatic check_link(input int n_pkts, input int first_edge);
      int                 idx;
      logic               gap_seen;
      mio_pkg::mio_beat_t exp_b;
      gap_seen = 1'b0;
      check_cnt++;
      if (beat_q.size() != n_pkts * `MIO_NBEATS) begin
         report_mismatch("link beat count", beat_q.size(), n_pkts * `MIO_NBEATS);
      end else begin
         for (int i = 0; i < n_pkts; i++) begin
            for (int j = 0; j < `MIO_NBEATS; j++) begin
               idx   = i * `MIO_NBEATS + j;
               exp_b = sent_q[i][`MIO_PW-1-`MIO_NMIO*j -: `MIO_NMIO];
               if (beat_q[idx] !== exp_b) begin
                  report_mismatch("link_data", beat_q[idx], exp_b);
               end
               if (beat_cyc_q[idx] != beat_cyc_q[0] + idx && !gap_seen) begin
                  gap_seen = 1'b1;
                  err_cnt++;
                  $display("Idle cycle on the link before beat %0d", idx);
               end
            end
         end
         if (first_edge >= 0 && beat_cyc_q[0] != first_edge) begin
            report_mismatch("first beat edge", beat_cyc_q[0], first_edge);
         end
      end
   endtask

   task automatic reset_dut();
      rst_n = 1'b0;
      repeat (10) @(negedge sys_clk);            // 10 cycles in reset
      rst_n = 1'b1;
      exp_q.delete();
      clear_capture();
   endtask

   // ####################
   // Tests
   // ####################

   task automatic test_reset_values();
      check_cnt++;
      if (tx_full !== 1'b0)     report_mismatch("tx_full", tx_full, 0);
      if (tx_overflow !== 1'b0) report_mismatch("tx_overflow", tx_overflow, 0);
      if (link_access !== 1'b0) report_mismatch("link_access", link_access, 0);
      if (rx_access !== 1'b0)   report_mismatch("rx_access", rx_access, 0);
   endtask

   task automatic test_single();
      mio_pkg::mio_packet_t pkt;
      int                   base;
      base = rx_cnt;
      clear_capture();
      make_packet(pkt);
      drive_strobe(pkt, 1'b1);                   // Idle buffer takes it
      idle_inputs();
      wait_rx(base + 1, 40);
      check_cnt++;
      if (last_rx_edge - strobe_edge != 14) begin
         report_mismatch("rx_access latency", last_rx_edge - strobe_edge, 14);
      end
      check_link(1, strobe_edge + 1);            // Beat 0 right after the pop edge
   endtask

   task automatic test_burst4();
      mio_pkg::mio_packet_t pkt;
      int                   base;
      base = rx_cnt;
      clear_capture();
      for (int i = 0; i < 4; i++) begin
         make_packet(pkt);
         drive_strobe(pkt, 1'b1);                // One popped, never full
      end
      idle_inputs();
      wait_rx(base + 4, 100);
      check_link(4, -1);
   endtask

   task automatic test_overflow();
      mio_pkg::mio_packet_t pkt;
      int                   base;
      base = rx_cnt;
      clear_capture();
      check_cnt++;
      if (tx_overflow !== 1'b0) report_mismatch("tx_overflow", tx_overflow, 0);
      for (int i = 0; i < 6; i++) begin
         make_packet(pkt);
         drive_strobe(pkt, i < 5);               // Four buffered plus one popped
      end
      idle_inputs();
      check_cnt++;
      if (tx_overflow !== 1'b1) report_mismatch("tx_overflow", tx_overflow, 1);
      wait_rx(base + 5, 150);
      repeat (20) @(negedge sys_clk);            // Nothing more may arrive
      check_cnt++;
      if (rx_cnt != base + 5) report_mismatch("packets received", rx_cnt - base, 5);
      if (tx_overflow !== 1'b1) report_mismatch("tx_overflow", tx_overflow, 1);
      check_link(5, -1);
   endtask

   task automatic test_reset_clear();
      @(negedge sys_clk);
      rst_n = 1'b0;
      repeat (3) @(negedge sys_clk);
      check_cnt++;
      if (tx_overflow !== 1'b0) report_mismatch("tx_overflow", tx_overflow, 0);
      rst_n = 1'b1;
      exp_q.delete();
      test_single();                             // Link works again
   endtask

   // ####################
   // Main sequence
   // ####################

   initial begin
      rst_n     = 1'b0;
      tx_access = 1'b0;
      tx_packet = '0;
      lfsr      = 32'h7d2daaf9;
      reset_dut();
      test_reset_values();
      test_single();
      test_burst4();
      test_overflow();
      test_reset_clear();
      repeat (5) @(negedge sys_clk);
      if (exp_q.size() != 0) begin
         err_cnt++;
         $display("%0d accepted packets never came back", exp_q.size());
      end
      $display("Summary %0d checks, %0d errors, %0d packets, %0d link beats",
               check_cnt, err_cnt, rx_cnt, beat_cnt);
      if (err_cnt == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

/* compile.f */
+incdir+.
mio_pkg.sv
mio_packet_fifo.sv
mio_serializer.sv
mio_deserializer.sv
mio_top.sv
tb_mio_top.sv

/* Makefile */
# Verilator build and run for the MIO link

VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only -Wall --timing
TOP       = tb_mio_top
FILELIST  = compile.f
OBJDIR    = obj_dir
LOG       = sim.log
PASS_MSG  = ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# The run passes only if the log holds the pass line
run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
